// ==== src/tag_pkg.sv ====
package tag_pkg;

  //////////////////////////////
  // Field widths
  //////////////////////////////

  // Client select field of a packet
  localparam int tag_id_width_gp = 5;

  // Destination id carried in a client payload
  localparam int tag_did_width_gp = 8;

  //////////////////////////////
  // Packet layout
  //////////////////////////////

  typedef struct packed
  {
    logic                        reset;
    logic [tag_did_width_gp-1:0] did;
  } tag_payload_s;

  // Field order here is also the bit order on the serial line
  typedef struct packed
  {
    logic [tag_id_width_gp-1:0] id;
    logic                       data_not_reset;
    tag_payload_s               payload;
  } tag_packet_s;

  // Start bit plus packet
  localparam int tag_packet_len_gp = 1 + $bits(tag_packet_s);

  //////////////////////////////
  // FSM states
  //////////////////////////////

  typedef enum logic {e_replay_idle, e_replay_send} replay_state_e;

  typedef enum logic {e_master_wait_start, e_master_shift} master_state_e;

endpackage

// ==== src/tag_trace_replay.sv ====
`timescale 1ns/1ps

module tag_trace_replay
  import tag_pkg::*;
  (
    input  logic        clk_i,
    input  logic        reset_i,

    input  tag_packet_s pkt_i,
    input  logic        pkt_valid_i,
    output logic        pkt_ready_o,

    output logic        tag_data_o,
    output logic        tag_en_o
  );

  localparam int pkt_width_lp = $bits(tag_packet_s);
  localparam int cnt_width_lp = $clog2(tag_packet_len_gp);
  localparam logic [cnt_width_lp-1:0] last_bit_lp = cnt_width_lp'(tag_packet_len_gp - 1);

  replay_state_e             state_r;
  logic [cnt_width_lp-1:0]   cnt_r;
  logic [pkt_width_lp-1:0]   shift_r;
  logic                      data_r;
  logic                      en_r;
  logic                      accept;

  assign pkt_ready_o = (state_r == e_replay_idle);
  assign accept      = pkt_valid_i & pkt_ready_o;

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  // Start bit goes out on the edge of accept, packet bits follow
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_replay_idle;
      cnt_r   <= '0;
      data_r  <= 1'b0;
      en_r    <= 1'b0;
    end
    else
    begin
      case (state_r)
        e_replay_idle:
        begin
          if (accept)
          begin
            state_r <= e_replay_send;
            cnt_r   <= '0;
            data_r  <= 1'b1;
            en_r    <= 1'b1;
          end
        end

        e_replay_send:
        begin
          if (cnt_r == last_bit_lp)
          begin
            state_r <= e_replay_idle;
            data_r  <= 1'b0;
            en_r    <= 1'b0;
          end
          else
          begin
            cnt_r  <= cnt_r + 1'b1;
            data_r <= shift_r[pkt_width_lp-1];
          end
        end

        default:
        begin
          state_r <= e_replay_idle;
        end
      endcase
    end
  end

  //////////////////////////////
  // Packet shifter
  //////////////////////////////

  // MSB first
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      shift_r <= pkt_i;
    end
    else if (state_r == e_replay_send)
    begin
      shift_r <= {shift_r[pkt_width_lp-2:0], 1'b0};
    end
  end

  assign tag_data_o = data_r;
  assign tag_en_o   = en_r;

  // Line busy and input ready are mutually exclusive
  a_ready_vs_en: assert property (@(posedge clk_i) disable iff (reset_i)
    !(pkt_ready_o && tag_en_o))
    else $error("replay ready while tag line enabled");

endmodule

// ==== src/tag_master.sv ====
`timescale 1ns/1ps

module tag_master
  import tag_pkg::*;
  #(
    parameter int num_clients_p = 22
  )
  (
    input  logic        clk_i,
    input  logic        reset_i,

    input  logic        tag_data_i,
    input  logic        tag_en_i,

    output tag_packet_s pkt_o,
    output logic        pkt_valid_o
  );

  localparam int pkt_width_lp = $bits(tag_packet_s);
  localparam int cnt_width_lp = $clog2(pkt_width_lp);
  localparam logic [cnt_width_lp-1:0] last_bit_lp = cnt_width_lp'(pkt_width_lp - 1);

  master_state_e             state_r;
  logic [cnt_width_lp-1:0]   cnt_r;
  logic [pkt_width_lp-1:0]   shift_r;
  logic                      valid_r;
  logic                      sample;

  // Data bit only counts while the line is enabled
  assign sample = tag_en_i & (state_r == e_master_shift);

  //////////////////////////////
  // Framing FSM
  //////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_master_wait_start;
      cnt_r   <= '0;
      valid_r <= 1'b0;
    end
    else
    begin
      valid_r <= 1'b0;

      case (state_r)
        e_master_wait_start:
        begin
          if (tag_en_i && tag_data_i)
          begin
            state_r <= e_master_shift;
            cnt_r   <= '0;
          end
        end

        e_master_shift:
        begin
          if (tag_en_i)
          begin
            if (cnt_r == last_bit_lp)
            begin
              // Last packet bit is in
              state_r <= e_master_wait_start;
              valid_r <= 1'b1;
            end
            else
            begin
              cnt_r <= cnt_r + 1'b1;
            end
          end
        end

        default:
        begin
          state_r <= e_master_wait_start;
        end
      endcase
    end
  end

  //////////////////////////////
  // Packet assembly
  //////////////////////////////

  // Holds still until the next start bit, so it can drive pkt_o directly
  always_ff @(posedge clk_i)
  begin
    if (sample)
    begin
      shift_r <= {shift_r[pkt_width_lp-2:0], tag_data_i};
    end
  end

  assign pkt_o       = tag_packet_s'(shift_r);
  assign pkt_valid_o = valid_r;

  // Id field must be able to address every client
  initial
  begin
    assert (num_clients_p <= (1 << tag_id_width_gp))
      else $fatal(1, "num_clients_p too large for id field");
  end

  // Packets are at least a full frame apart
  a_valid_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    pkt_valid_o |=> !pkt_valid_o)
    else $error("master valid held for two cycles");

endmodule

// ==== src/tag_client_bank.sv ====
`timescale 1ns/1ps

module tag_client_bank
  import tag_pkg::*;
  #(
    parameter int num_clients_p = 22
  )
  (
    input  logic                               clk_i,
    input  logic                               reset_i,

    input  tag_packet_s                        pkt_i,
    input  logic                               pkt_valid_i,

    output tag_payload_s [num_clients_p-1:0]   client_data_o,
    output logic         [num_clients_p-1:0]   client_new_o
  );

  localparam logic [tag_id_width_gp:0] num_clients_lp = (tag_id_width_gp + 1)'(num_clients_p);

  tag_payload_s [num_clients_p-1:0] data_r;
  logic         [num_clients_p-1:0] new_r;
  logic                             hit;

  // Out of range ids fall through
  assign hit = pkt_valid_i & ({1'b0, pkt_i.id} < num_clients_lp);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      data_r <= '0;
      new_r  <= '0;
    end
    else
    begin
      new_r <= '0;
      if (hit)
      begin
        new_r[pkt_i.id] <= 1'b1;
        // Reset packet puts the client back to default
        if (pkt_i.data_not_reset)
          data_r[pkt_i.id] <= pkt_i.payload;
        else
          data_r[pkt_i.id] <= '0;
      end
    end
  end

  assign client_data_o = data_r;
  assign client_new_o  = new_r;

  a_new_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(client_new_o))
    else $error("more than one client new bit high");

endmodule

// ==== src/gateway_tag_top.sv ====
`timescale 1ns/1ps

module gateway_tag_top
  import tag_pkg::*;
  #(
    parameter int num_clients_p = 22
  )
  (
    input  logic                               clk_i,
    input  logic                               reset_i,

    input  tag_packet_s                        pkt_i,
    input  logic                               pkt_valid_i,
    output logic                               pkt_ready_o,

    output logic                               tag_data_o,
    output logic                               tag_en_o,

    output tag_payload_s [num_clients_p-1:0]   client_data_o,
    output logic         [num_clients_p-1:0]   client_new_o
  );

  tag_packet_s master_pkt_lo;
  logic        master_valid_lo;

  //////////////////////////////
  // Trace replay onto tag line
  //////////////////////////////

  tag_trace_replay replay0
    (.clk_i       (clk_i)
    ,.reset_i     (reset_i)
    ,.pkt_i       (pkt_i)
    ,.pkt_valid_i (pkt_valid_i)
    ,.pkt_ready_o (pkt_ready_o)
    ,.tag_data_o  (tag_data_o)
    ,.tag_en_o    (tag_en_o)
    );

  //////////////////////////////
  // Tag master and clients
  //////////////////////////////

  tag_master #(.num_clients_p(num_clients_p)) master0
    (.clk_i       (clk_i)
    ,.reset_i     (reset_i)
    ,.tag_data_i  (tag_data_o)
    ,.tag_en_i    (tag_en_o)
    ,.pkt_o       (master_pkt_lo)
    ,.pkt_valid_o (master_valid_lo)
    );

  tag_client_bank #(.num_clients_p(num_clients_p)) bank0
    (.clk_i         (clk_i)
    ,.reset_i       (reset_i)
    ,.pkt_i         (master_pkt_lo)
    ,.pkt_valid_i   (master_valid_lo)
    ,.client_data_o (client_data_o)
    ,.client_new_o  (client_new_o)
    );

endmodule

// ==== sim/tb_gateway_tag.sv ====
`timescale 1ns/1ps

module tb_gateway_tag
  import tag_pkg::*;
  ();

  // Matches the gateway_tag_top default, dut0 is built with no override
  localparam int num_clients_lp = 22;
  localparam int idx_width_lp   = $clog2(num_clients_lp);
  localparam int directed_lp    = 7;
  localparam int random_lp      = 200;
  localparam int cycle_limit_lp = (directed_lp + random_lp) * 20 + 200;

  logic                              clk_i;
  logic                              reset_i;
  tag_packet_s                       pkt_i;
  logic                              pkt_valid_i;
  logic                              pkt_ready_o;
  logic                              tag_data_o;
  logic                              tag_en_o;
  tag_payload_s [num_clients_lp-1:0] client_data_o;
  logic         [num_clients_lp-1:0] client_new_o;

  int           cyc;
  int           line_idx;
  int           bank_idx;
  tag_packet_s  acc_pkt[$];
  int           acc_cyc[$];
  tag_payload_s model_data [num_clients_lp];

  gateway_tag_top dut0
    (.clk_i         (clk_i)
    ,.reset_i       (reset_i)
    ,.pkt_i         (pkt_i)
    ,.pkt_valid_i   (pkt_valid_i)
    ,.pkt_ready_o   (pkt_ready_o)
    ,.tag_data_o    (tag_data_o)
    ,.tag_en_o      (tag_en_o)
    ,.client_data_o (client_data_o)
    ,.client_new_o  (client_new_o)
    );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i)
  begin
    cyc <= cyc + 1;
    if (cyc >= cycle_limit_lp)
    begin
      $display("Timeout after %0d cycles, only %0d of %0d packets reached the clients",
               cyc, bank_idx, acc_cyc.size());
      $display("Test failures found");
      $fatal(1, "run did not finish in time");
    end
  end

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected)
    begin
      $display("ERR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      $display("Test failures found");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic compare_clients();
    logic [idx_width_lp-1:0] idx;
    for (int i = 0; i < num_clients_lp; i++)
    begin
      idx = idx_width_lp'(i);
      check_value($sformatf("client_data_o[%0d]", i), 64'(client_data_o[idx]),
                  64'(model_data[idx]));
    end
  endtask

  //////////////////////////////
  // Line and client model
  //////////////////////////////

  // Values seen here are the ones the next rising edge samples
  always @(negedge clk_i)
  begin : monitor
    int                             s;
    int                             k;
    logic                           exp_en;
    logic                           exp_data;
    logic [tag_packet_len_gp-1:0]   frame;
    logic [num_clients_lp-1:0]      exp_new;
    logic [idx_width_lp-1:0]        idx;
    tag_packet_s                    p;
    if (!reset_i)
    begin
      s = cyc + 1;

      // Frame of the packet accepted at A covers samples A+1 to A+16
      while (line_idx < acc_cyc.size() && acc_cyc[line_idx] + tag_packet_len_gp < s)
      begin
        line_idx++;
      end
      exp_en   = 1'b0;
      exp_data = 1'b0;
      if (line_idx < acc_cyc.size() && acc_cyc[line_idx] + 1 <= s)
      begin
        k        = s - acc_cyc[line_idx];
        frame    = {1'b1, acc_pkt[line_idx]};
        frame    = frame << (k - 1);
        exp_en   = 1'b1;
        exp_data = frame[tag_packet_len_gp-1];
      end
      check_value("tag_en_o", 64'(tag_en_o), 64'(exp_en));
      check_value("pkt_ready_o", 64'(pkt_ready_o), 64'(!exp_en));
      if (exp_en)
        check_value("tag_data_o", 64'(tag_data_o), 64'(exp_data));

      // Client update lands 18 cycles after the accept
      exp_new = '0;
      if (bank_idx < acc_cyc.size() && acc_cyc[bank_idx] + 18 == s)
      begin
        p = acc_pkt[bank_idx];
        if (int'(p.id) < num_clients_lp)
        begin
          idx          = idx_width_lp'(p.id);
          exp_new[idx] = 1'b1;
          model_data[idx] = p.data_not_reset ? p.payload : '0;
        end
        bank_idx++;
      end
      check_value("client_new_o", 64'(client_new_o), 64'(exp_new));
      compare_clients();

      if (pkt_valid_i && pkt_ready_o)
      begin
        acc_pkt.push_back(pkt_i);
        acc_cyc.push_back(s);
      end
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  function automatic tag_packet_s make_packet(input logic [tag_id_width_gp-1:0] id,
                                              input logic dnr, input logic rst,
                                              input logic [tag_did_width_gp-1:0] did);
    tag_packet_s p;
    p.id             = id;
    p.data_not_reset = dnr;
    p.payload.reset  = rst;
    p.payload.did    = did;
    return p;
  endfunction

  function automatic tag_packet_s random_packet();
    tag_packet_s p;
    p.id             = tag_id_width_gp'($urandom_range(0, 31));
    p.data_not_reset = ($urandom_range(0, 3) != 0);
    p.payload.reset  = 1'($urandom_range(0, 1));
    p.payload.did    = tag_did_width_gp'($urandom_range(0, 255));
    return p;
  endfunction

  // Called on a rising edge, returns on the edge that accepts
  task automatic send_packet(input tag_packet_s p, input int gap);
    logic ready_seen;
    repeat (gap) @(posedge clk_i);
    pkt_i       <= p;
    pkt_valid_i <= 1'b1;
    do
    begin
      @(negedge clk_i);
      ready_seen = pkt_ready_o;
      @(posedge clk_i);
    end
    while (!ready_seen);
    pkt_valid_i <= 1'b0;
  endtask

  task automatic wait_drain();
    while (bank_idx < acc_cyc.size())
    begin
      @(posedge clk_i);
    end
    repeat (3) @(posedge clk_i);
  endtask

  initial
  begin
    void'($urandom(56));
    clk_i       = 1'b0;
    reset_i     = 1'b1;
    pkt_i       = '0;
    pkt_valid_i = 1'b0;
    cyc         = 0;
    line_idx    = 0;
    bank_idx    = 0;
    for (int i = 0; i < num_clients_lp; i++)
    begin
      model_data[i] = '0;
    end

    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;

    // Idle state right after reset
    @(negedge clk_i);
    check_value("pkt_ready_o", 64'(pkt_ready_o), 64'h1);
    check_value("tag_en_o", 64'(tag_en_o), 64'h0);
    check_value("tag_data_o", 64'(tag_data_o), 64'h0);
    check_value("client_new_o", 64'(client_new_o), 64'h0);
    compare_clients();
    @(posedge clk_i);

    // Writes, a reset packet and ids past the last client
    send_packet(make_packet(5'd3, 1'b1, 1'b1, 8'ha5), 0);
    send_packet(make_packet(5'd21, 1'b1, 1'b0, 8'h3c), 2);
    send_packet(make_packet(5'd3, 1'b0, 1'b1, 8'hff), 0);
    send_packet(make_packet(5'd22, 1'b1, 1'b1, 8'h77), 5);
    send_packet(make_packet(5'd31, 1'b1, 1'b0, 8'h12), 0);
    send_packet(make_packet(5'd0, 1'b1, 1'b0, 8'h01), 20);
    send_packet(make_packet(5'd21, 1'b0, 1'b0, 8'h00), 0);
    wait_drain();
    check_value("client_data_o[0]", 64'(client_data_o[0]), 64'h001);
    check_value("client_data_o[3]", 64'(client_data_o[3]), 64'h000);
    check_value("client_data_o[21]", 64'(client_data_o[21]), 64'h000);

    // Random trace, gaps up to 16 still give back to back accepts
    for (int n = 0; n < random_lp; n++)
    begin
      send_packet(random_packet(), int'($urandom_range(0, 24)));
    end
    wait_drain();

    @(negedge clk_i);
    compare_clients();
    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== tb.f ====
src/tag_pkg.sv
src/tag_trace_replay.sv
src/tag_master.sv
src/tag_client_bank.sv
src/gateway_tag_top.sv
sim/tb_gateway_tag.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_gateway_tag \
  -f tb.f \
  -Mdir obj_dir

# Simulator exit status is not trusted, the pass line decides
output="$(./obj_dir/Vtb_gateway_tag 2>&1 || true)"
echo "$output"

if echo "$output" | grep -qx 'All tests passed!'; then
  exit 0
else
  exit 1
fi
